// ==== tb.f ====
+incdir+.
irq_pkg.sv
encoder.sv
irq_gateway.sv
irq_regs.sv
irq_ctrl.sv
tb_irq_ctrl.sv

// ==== Bender.yml ====
package:
  name: irq_ctrl

sources:
  - irq_pkg.sv
  - encoder.sv
  - irq_gateway.sv
  - irq_regs.sv
  - irq_ctrl.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_irq_ctrl.sv

// ==== tb_irq_vectors.svh ====
// Columns: src, op, addr, wdata, expected rdata, check rdata, expected irq.
// A read sees the state from before its own row, so reads keep src unchanged.
task automatic load_table();
  // Reset state, everything reads back as zero.
  add_row(32'h00, op_idle,  irq_pkg::addr_enable,  32'h0,         32'h0,         1'b0, 1'b0);
  add_row(32'h00, op_read,  irq_pkg::addr_enable,  32'h0,         32'h0,         1'b1, 1'b0);
  add_row(32'h00, op_read,  irq_pkg::addr_pending, 32'h0,         32'h0,         1'b1, 1'b0);
  add_row(32'h00, op_read,  irq_pkg::addr_claim,   32'h0,         32'h0,         1'b1, 1'b0);
  // Enable all, then edges on sources 5 and 3.
  add_row(32'h00, op_write, irq_pkg::addr_enable,  32'hffff_ffff, 32'h0,         1'b0, 1'b0);
  add_row(32'h28, op_idle,  irq_pkg::addr_enable,  32'h0,         32'h0,         1'b0, 1'b1);
  add_row(32'h28, op_read,  irq_pkg::addr_pending, 32'h0,         32'h28,        1'b1, 1'b1);
  // Lowest index first, then 5, then nothing left.
  add_row(32'h28, op_read,  irq_pkg::addr_claim,   32'h0,         32'h8000_0003, 1'b1, 1'b1);
  add_row(32'h28, op_read,  irq_pkg::addr_claim,   32'h0,         32'h8000_0005, 1'b1, 1'b0);
  add_row(32'h28, op_read,  irq_pkg::addr_claim,   32'h0,         32'h0,         1'b1, 1'b0);
  // Edge on source 3 while in service is dropped.
  add_row(32'h00, op_idle,  irq_pkg::addr_enable,  32'h0,         32'h0,         1'b0, 1'b0);
  add_row(32'h08, op_idle,  irq_pkg::addr_enable,  32'h0,         32'h0,         1'b0, 1'b0);
  add_row(32'h08, op_read,  irq_pkg::addr_pending, 32'h0,         32'h0,         1'b1, 1'b0);
  // Complete 3, a fresh edge sets pending again.
  add_row(32'h08, op_write, irq_pkg::addr_claim,   32'h3,         32'h0,         1'b0, 1'b0);
  add_row(32'h00, op_idle,  irq_pkg::addr_enable,  32'h0,         32'h0,         1'b0, 1'b0);
  add_row(32'h08, op_idle,  irq_pkg::addr_enable,  32'h0,         32'h0,         1'b0, 1'b1);
  add_row(32'h08, op_read,  irq_pkg::addr_pending, 32'h0,         32'h08,        1'b1, 1'b1);
  // Mask source 3; source 7 wins even though 3 is pending.
  add_row(32'h08, op_write, irq_pkg::addr_enable,  32'hffff_fff7, 32'h0,         1'b0, 1'b0);
  add_row(32'h88, op_idle,  irq_pkg::addr_enable,  32'h0,         32'h0,         1'b0, 1'b1);
  add_row(32'h88, op_read,  irq_pkg::addr_claim,   32'h0,         32'h8000_0007, 1'b1, 1'b0);
  add_row(32'h88, op_read,  irq_pkg::addr_claim,   32'h0,         32'h0,         1'b1, 1'b0);
  add_row(32'h88, op_read,  irq_pkg::addr_pending, 32'h0,         32'h08,        1'b1, 1'b0);
  add_row(32'h88, op_write, irq_pkg::addr_claim,   32'h7,         32'h0,         1'b0, 1'b0);
  add_row(32'h88, op_write, irq_pkg::addr_claim,   32'h5,         32'h0,         1'b0, 1'b0);
  // Unmapped address reads zero.
  add_row(32'h88, op_read,  4'hc,                  32'h0,         32'h0,         1'b1, 1'b0);
  add_row(32'h88, op_read,  irq_pkg::addr_enable,  32'h0,         32'hffff_fff7, 1'b1, 1'b0);
  // Unmask 3 and drain it.
  add_row(32'h88, op_write, irq_pkg::addr_enable,  32'hffff_ffff, 32'h0,         1'b0, 1'b1);
  add_row(32'h88, op_read,  irq_pkg::addr_claim,   32'h0,         32'h8000_0003, 1'b1, 1'b0);
  add_row(32'h88, op_write, irq_pkg::addr_claim,   32'h3,         32'h0,         1'b0, 1'b0);
  add_row(32'h88, op_read,  irq_pkg::addr_pending, 32'h0,         32'h0,         1'b1, 1'b0);
endtask

// ==== tb_irq_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

// Table-driven testbench for the interrupt controller.
module tb_irq_ctrl;

  localparam int n_src = 32;

  // Bus operation codes used in the table.
  localparam logic [1:0] op_idle  = 2'd0;
  localparam logic [1:0] op_read  = 2'd1;
  localparam logic [1:0] op_write = 2'd2;

  // One table row.
  typedef struct packed {
    logic [n_src-1:0] src;
    logic [1:0]       op;
    logic [3:0]       addr;
    logic [31:0]      wdata;
    logic [31:0]      exp_rdata;
    logic             chk_rdata;
    logic             exp_irq;
  } row_t;

  logic                  clk;
  logic                  arst_n;
  logic [n_src-1:0]      src;
  irq_pkg::irq_bus_req_t bus;
  logic [31:0]           rdata;
  logic                  rvalid;
  logic                  irq;

  row_t rows[$];
  int   errors;
  int   checks;
  logic loaded;

  irq_ctrl #(
    .n_src (n_src)
  ) dut (
    .clk    (clk),
    .arst_n (arst_n),
    .src    (src),
    .bus    (bus),
    .rdata  (rdata),
    .rvalid (rvalid),
    .irq    (irq)
  );

  // 10 ns clock.
  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Table handling
  ////////////////////////////////////////////////////////////////////////////

  task automatic add_row(input logic [n_src-1:0] s, input logic [1:0] op,
                         input logic [3:0] addr, input logic [31:0] wdata,
                         input logic [31:0] exp_rdata, input logic chk_rdata,
                         input logic exp_irq);
    row_t r;
    r.src       = s;
    r.op        = op;
    r.addr      = addr;
    r.wdata     = wdata;
    r.exp_rdata = exp_rdata;
    r.chk_rdata = chk_rdata;
    r.exp_irq   = exp_irq;
    rows.push_back(r);
  endtask

  `include "tb_irq_vectors.svh"

  // Drive on a falling edge, hold the strobe for one cycle.
  // Read reply is sampled one cycle later, irq one cycle after that.
  task automatic apply_row(input row_t r, input int idx);
    logic exp_rvalid;
    exp_rvalid = (r.op == op_read);
    @(negedge clk);
    src       = r.src;
    bus       = '0;
    bus.wen   = (r.op == op_write);
    bus.ren   = exp_rvalid;
    bus.addr  = r.addr;
    bus.wdata = r.wdata;
    @(negedge clk);
    bus = '0;
    checks++;
    if (rvalid !== exp_rvalid) begin
      errors++;
      $display("MISMATCH at %0t: row %0d rvalid %b expected %b",
               $time, idx, rvalid, exp_rvalid);
    end
    if (r.chk_rdata) begin
      checks++;
      if (rdata !== r.exp_rdata) begin
        errors++;
        $display("MISMATCH at %0t: row %0d rdata %h expected %h",
                 $time, idx, rdata, r.exp_rdata);
      end
    end
    @(negedge clk);
    checks++;
    if (irq !== r.exp_irq) begin
      errors++;
      $display("MISMATCH at %0t: row %0d irq %b expected %b", $time, idx, irq, r.exp_irq);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    clk    = 1'b0;
    arst_n = 1'b0;
    src    = '0;
    bus    = '0;
    errors = 0;
    checks = 0;
    loaded = 1'b0;
    load_table();
    loaded = 1'b1;
    // Reset spans three rising edges.
    repeat (3) @(negedge clk);
    arst_n = 1'b1;
    foreach (rows[i]) begin
      apply_row(rows[i], i);
    end
    $display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  // Three cycles per row plus margin for reset.
  initial begin : watchdog
    wait (loaded);
    repeat (rows.size() * 3 + 20) @(posedge clk);
    $display("Timeout: the table did not finish in the expected number of cycles.");
    $display("** FAIL **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== irq_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

// Interrupt controller top level.
// Gateway feeds the encoder; the register block claims and completes.
module irq_ctrl #(
  parameter int n_src = 32
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [n_src-1:0]      src,
  input  irq_pkg::irq_bus_req_t bus,
  output logic [31:0]           rdata,
  output logic                  rvalid,
  output logic                  irq
);

  ////////////////////////////////////////////////////////////////////////////
  // Internal nets
  ////////////////////////////////////////////////////////////////////////////

  logic [n_src-1:0]         pending;
  logic [n_src-1:0]         in_service;
  logic [n_src-1:0]         enable;
  logic [n_src-1:0]         candidates;
  logic                     enc_strobe;
  logic [irq_pkg::id_w-1:0] enc_id;
  logic                     claim;
  logic [irq_pkg::id_w-1:0] claim_id;
  logic                     complete;
  logic [irq_pkg::id_w-1:0] complete_id;

  // Sources in service are hidden from the encoder.
  assign candidates = pending & ~in_service;

  irq_gateway #(
    .n_src (n_src)
  ) u_gateway (
    .clk         (clk),
    .arst_n      (arst_n),
    .src         (src),
    .claim       (claim),
    .claim_id    (claim_id),
    .complete    (complete),
    .complete_id (complete_id),
    .pending     (pending),
    .in_service  (in_service)
  );

  encoder #(
    .n_src (n_src)
  ) u_encoder (
    .in     (candidates),
    .ena    (enable),
    .strobe (enc_strobe),
    .out    (enc_id)
  );

  irq_regs #(
    .n_src (n_src)
  ) u_regs (
    .clk         (clk),
    .arst_n      (arst_n),
    .bus         (bus),
    .pending     (pending),
    .enc_strobe  (enc_strobe),
    .enc_id      (enc_id),
    .enable      (enable),
    .claim       (claim),
    .claim_id    (claim_id),
    .complete    (complete),
    .complete_id (complete_id),
    .rdata       (rdata),
    .rvalid      (rvalid)
  );

  // Registered interrupt line, one cycle behind the encoder.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      irq <= 1'b0;
    end else begin
      irq <= enc_strobe;
    end
  end

endmodule

`default_nettype wire

// ==== irq_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

// Register block.
// Decodes the strobe bus, holds the enable mask and answers reads.
module irq_regs #(
  parameter int n_src = 32
) (
  input  logic                     clk,
  input  logic                     arst_n,
  input  irq_pkg::irq_bus_req_t    bus,
  input  logic [n_src-1:0]         pending,
  input  logic                     enc_strobe,
  input  logic [irq_pkg::id_w-1:0] enc_id,
  output logic [n_src-1:0]         enable,
  output logic                     claim,
  output logic [irq_pkg::id_w-1:0] claim_id,
  output logic                     complete,
  output logic [irq_pkg::id_w-1:0] complete_id,
  output logic [31:0]              rdata,
  output logic                     rvalid
);

  ////////////////////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////////////////////

  logic hit_enable;
  logic hit_pending;
  logic hit_claim;

  assign hit_enable  = (bus.addr == irq_pkg::addr_enable);
  assign hit_pending = (bus.addr == irq_pkg::addr_pending);
  assign hit_claim   = (bus.addr == irq_pkg::addr_claim);

  ////////////////////////////////////////////////////////////////////////////
  // Claim and complete pulses
  ////////////////////////////////////////////////////////////////////////////

  // Claim fires only when the encoder has a candidate.
  // The gateway takes it at the edge that ends the read cycle.
  assign claim    = bus.ren & hit_claim & enc_strobe;
  assign claim_id = enc_id;

  // Complete takes the id from the low bits of the write data.
  assign complete    = bus.wen & hit_claim;
  assign complete_id = bus.wdata[irq_pkg::id_w-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Enable mask
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      enable <= '0;
    end else if (bus.wen && hit_enable) begin
      enable <= bus.wdata[n_src-1:0];
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read data
  ////////////////////////////////////////////////////////////////////////////

  // Read mux, zero for anything unmapped.
  logic [31:0] rdata_d;

  always_comb begin
    rdata_d = '0;
    if (hit_enable) begin
      rdata_d = 32'(enable);
    end else if (hit_pending) begin
      rdata_d = 32'(pending);
    end else if (hit_claim) begin
      // Valid flag plus id; id is zero when nothing is valid.
      rdata_d[irq_pkg::claim_valid_bit] = enc_strobe;
      rdata_d[irq_pkg::id_w-1:0]        = enc_strobe ? enc_id : '0;
    end
  end

  // Answer follows the read strobe by one cycle.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rvalid <= 1'b0;
    end else begin
      rvalid <= bus.ren;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rdata <= '0;
    end else if (bus.ren) begin
      rdata <= rdata_d;
    end
  end

  // One access per cycle on this bus.
  a_no_rw_overlap : assert property (@(posedge clk) disable iff (!arst_n)
    !(bus.wen && bus.ren))
    else $error("write and read strobes high in the same cycle");

endmodule

`default_nettype wire

// ==== irq_gateway.sv ====
`timescale 1ns/1ps
`default_nettype none

// Source gateway.
// Turns rising edges into pending bits and tracks the sources in service.
module irq_gateway #(
  parameter int n_src = 32
) (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic [n_src-1:0]         src,
  input  logic                     claim,
  input  logic [irq_pkg::id_w-1:0] claim_id,
  input  logic                     complete,
  input  logic [irq_pkg::id_w-1:0] complete_id,
  output logic [n_src-1:0]         pending,
  output logic [n_src-1:0]         in_service
);

  ////////////////////////////////////////////////////////////////////////////
  // Edge detection
  ////////////////////////////////////////////////////////////////////////////

  // Stored copy of the sources from the last edge.
  logic [n_src-1:0] src_q;
  // High where src is high now and was low before.
  logic [n_src-1:0] src_rise;

  assign src_rise = src & ~src_q;

  ////////////////////////////////////////////////////////////////////////////
  // Pending and in-service update
  ////////////////////////////////////////////////////////////////////////////

  logic [n_src-1:0] pending_d;
  logic [n_src-1:0] in_service_d;

  always_comb begin
    // An edge on a source in service is dropped.
    // An edge on a pending source merges with the earlier one.
    pending_d    = pending | (src_rise & ~in_service);
    in_service_d = in_service;
    // Claim moves the source from pending to in service.
    if (claim) begin
      pending_d[claim_id]    = 1'b0;
      in_service_d[claim_id] = 1'b1;
    end
    // Complete frees the source.
    if (complete) begin
      in_service_d[complete_id] = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      src_q      <= '0;
      pending    <= '0;
      in_service <= '0;
    end else begin
      src_q      <= src;
      pending    <= pending_d;
      in_service <= in_service_d;
    end
  end

  // The claim id comes from the encoder, so it must name a pending source.
  a_claim_pending : assert property (@(posedge clk) disable iff (!arst_n)
    claim |-> pending[claim_id])
    else $error("claim of a source that is not pending");

  // Software completes only what it claimed before.
  a_complete_in_service : assert property (@(posedge clk) disable iff (!arst_n)
    complete |-> in_service[complete_id])
    else $error("complete of a source that is not in service");

endmodule

`default_nettype wire

// ==== encoder.sv ====
`timescale 1ns/1ps
`default_nettype none

// Modified priority encoder.
// The lowest index with both request and enable set wins.
module encoder #(
  parameter int n_src = 32
) (
  input  logic [n_src-1:0]         in,
  input  logic [n_src-1:0]         ena,
  output logic                     strobe,
  output logic [irq_pkg::id_w-1:0] out
);

  // Requests that are allowed to compete.
  logic [n_src-1:0] req;

  assign req = in & ena;

  // Walk from the top index down.
  // A later hit overwrites an earlier one, so the lowest index is kept.
  always_comb begin
    strobe = 1'b0;
    out    = '0;
    for (int i = n_src - 1; i >= 0; i--) begin
      if (req[i]) begin
        strobe = 1'b1;
        out    = irq_pkg::id_w'(i);
      end
    end
  end

endmodule

`default_nettype wire

// ==== irq_pkg.sv ====
`default_nettype none

package irq_pkg;

  //////////////////////////////////////////////////////////////////////////
  // Register address map
  //////////////////////////////////////////////////////////////////////////

  // Per-source enable mask, read and write.
  localparam logic [3:0] addr_enable  = 4'h0;
  // Pending bits, read only.
  localparam logic [3:0] addr_pending = 4'h4;
  // Read claims the best source, write completes a source.
  localparam logic [3:0] addr_claim   = 4'h8;

  //////////////////////////////////////////////////////////////////////////
  // Claim word layout
  //////////////////////////////////////////////////////////////////////////

  // Set when the claim read returned a real source.
  localparam int claim_valid_bit = 31;
  // Source id sits in the low bits of the claim word.
  localparam int id_w = 5;

  //////////////////////////////////////////////////////////////////////////
  // Bus request
  //////////////////////////////////////////////////////////////////////////

  // Single-cycle strobes, no handshake.
  // wen and ren are never high together.
  typedef struct packed {
    logic        wen;
    logic        ren;
    logic [3:0]  addr;
    logic [31:0] wdata;
  } irq_bus_req_t;

endpackage

`default_nettype wire
